/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

    // Control flag indices
    // Each source group follows its field encoding, so the decoder can shift into place
    localparam int SET_DB_TO_ACC = 0, SET_DB_TO_PCL = 1, SET_DB_TO_PCH = 2,
                   SET_DB_TO_PSR = 3, SET_DB_TO_DATA = 4, SET_DB_HIGH = 5;
    localparam int SET_SB_TO_X = 6, SET_SB_TO_Y = 7, SET_SB_TO_SP = 8,
                   SET_SB_TO_ALU = 9, SET_SB_TO_ACC = 10, SET_SB_HIGH = 11;
    localparam int SET_ADL_TO_SP = 12, SET_ADL_TO_ALU = 13, SET_ADL_TO_PCL = 14,
                   SET_ADL_TO_DATA = 15, SET_ADL_FA = 16, SET_ADL_FB = 17,
                   SET_ADL_FC = 18, SET_ADL_FD = 19, SET_ADL_FE = 20,
                   SET_ADL_FF = 21, SET_ADL_00 = 22;
    localparam int SET_ADH_TO_PCH = 23, SET_ADH_TO_DATA = 24, SET_ADH_LOW = 25,
                   SET_ADH_TO_ONE = 26, SET_ADH_FF = 27;
    // Bridges, named after the receiving bus
    localparam int SET_SB_TO_DB = 28, SET_DB_TO_SB = 29, SET_ADH_TO_SB = 30;
    localparam int LOAD_X = 31, LOAD_Y = 32, LOAD_ACC = 33, LOAD_SP = 34,
                   LOAD_ALU = 35, LOAD_ABL = 36, LOAD_ABH = 37, LOAD_DOR = 38;
    localparam int PC_INC = 39, LOAD_PC = 40;
    localparam int SET_INPUT_A_TO_SB = 41, SET_INPUT_B_TO_DB = 42,
                   SET_INPUT_B_TO_NOT_DB = 43, SET_INPUT_B_TO_ADL = 44;
    localparam int ALU_ADD = 45, ALU_AND = 46, ALU_XOR = 47, ALU_OR = 48, ALU_R_SHIFT = 49;
    localparam int SET_ALU_CARRY_HIGH = 50, SET_ALU_CARRY_TO_PSR_CARRY = 51;
    localparam int SET_PSR_N_TO_DB7 = 52, SET_PSR_Z_TO_DBZERO = 53, SET_PSR_C_TO_ALU = 54,
                   SET_PSR_V_TO_ALU = 55, SET_PSR_ALL_TO_DB = 56, SET_PSR_C_HIGH = 57,
                   SET_PSR_C_LOW = 58;
    localparam int NUMFLAGS = 59;
    localparam int NUMLOADS = 8;

    // Field encodings, zero drives nothing
    localparam logic [2:0] DB_NONE = 3'd0, DB_ACC = 3'd1, DB_PCL = 3'd2, DB_PCH = 3'd3,
                           DB_PSR = 3'd4, DB_DATA = 3'd5, DB_FF = 3'd6;
    localparam logic [2:0] SB_NONE = 3'd0, SB_X = 3'd1, SB_Y = 3'd2, SB_SP = 3'd3,
                           SB_ALU = 3'd4, SB_ACC = 3'd5, SB_FF = 3'd6;
    localparam logic [3:0] ADL_NONE = 4'd0, ADL_SP = 4'd1, ADL_ALU = 4'd2, ADL_PCL = 4'd3,
                           ADL_DATA = 4'd4, ADL_FA = 4'd5, ADL_FB = 4'd6, ADL_FC = 4'd7,
                           ADL_FD = 4'd8, ADL_FE = 4'd9, ADL_FF = 4'd10, ADL_00 = 4'd11;
    localparam logic [2:0] ADH_NONE = 3'd0, ADH_PCH = 3'd1, ADH_DATA = 3'd2, ADH_00 = 3'd3,
                           ADH_01 = 3'd4, ADH_FF = 3'd5;
    localparam logic [1:0] BR_NONE = 2'd0, BR_SB_FROM_DB = 2'd1, BR_DB_FROM_SB = 2'd2,
                           BR_ADH_FROM_SB = 2'd3;
    // Bits of the loads mask
    localparam logic [7:0] LD_X = 8'h01, LD_Y = 8'h02, LD_ACC = 8'h04, LD_SP = 8'h08,
                           LD_ALU = 8'h10, LD_ABL = 8'h20, LD_ABH = 8'h40, LD_DOR = 8'h80;
    localparam logic       ALUA_ZERO = 1'b0, ALUA_SB = 1'b1;
    localparam logic [1:0] ALUB_DB = 2'd0, ALUB_NOT_DB = 2'd1, ALUB_ADL = 2'd2;
    localparam logic [2:0] OP_ADD = 3'd0, OP_AND = 3'd1, OP_XOR = 3'd2, OP_OR = 3'd3,
                           OP_SHR = 3'd4;
    localparam logic [1:0] CARRY_ZERO = 2'd0, CARRY_ONE = 2'd1, CARRY_PSR = 2'd2;
    localparam logic [2:0] PSR_NONE = 3'd0, PSR_NZ_DB = 3'd1, PSR_ALU = 3'd2,
                           PSR_LOAD_DB = 3'd3, PSR_SET_C = 3'd4, PSR_CLR_C = 3'd5;
    localparam logic [1:0] PCOP_HOLD = 2'd0, PCOP_INC = 2'd1, PCOP_LOAD = 2'd2,
                           PCOP_LOAD_INC = 2'd3;

    typedef logic [NUMFLAGS-1:0] flags_t;

    typedef struct packed {
        logic [2:0]          dbSrc;
        logic [2:0]          sbSrc;
        logic [3:0]          adlSrc;
        logic [2:0]          adhSrc;
        logic [1:0]          bridge;
        logic [NUMLOADS-1:0] loads;
        logic                aluA;
        logic [1:0]          aluB;
        logic [2:0]          aluOp;
        logic [1:0]          carrySel;
        logic [2:0]          psrOp;
        logic [1:0]          pcOp;   // Bit 0 increments, bit 1 loads from ADH:ADL
    } microOp_t;

    typedef struct packed {
        logic n, v, one, b, d, i, z, c;
    } psr_t;

    localparam psr_t       PSR_RESET = 8'h20;
    localparam logic [7:0] PCH_RESET = 8'hAA;
    localparam logic [7:0] PCL_RESET = 8'hBB;

endpackage

`default_nettype wire

/* internalBus.sv */
`default_nettype none

module internalBus #(
    parameter int INPUT_COUNT = 2
) (
    input  wire [INPUT_COUNT-1:0]      busSelect,
    input  wire [INPUT_COUNT-1:0][7:0] busInputs,
    output logic [7:0]                 busOutput
);

    // Wired OR of the enabled drivers, idle bus reads zero
    always_comb begin
        busOutput = 8'h00;
        for (int k = 0; k < INPUT_COUNT; k++) begin
            if (busSelect[k]) begin
                busOutput = busOutput | busInputs[k];
            end
        end
    end

endmodule

`default_nettype wire

/* alu.sv */
`default_nettype none

module alu (
    input  wire [7:0]           dbIn,
    input  wire [7:0]           adlIn,
    input  wire [7:0]           sbIn,
    input  wire cpuPkg::flags_t flags,
    input  wire                 carryIn,
    output logic [7:0]          result,
    output logic                carryOut,
    output logic                overflow
);
    logic [7:0] aIn;
    logic [7:0] bIn;
    logic [8:0] sum;

    assign aIn = flags[cpuPkg::SET_INPUT_A_TO_SB] ? sbIn : 8'h00;
    assign bIn = ({8{flags[cpuPkg::SET_INPUT_B_TO_DB]}} & dbIn)
               | ({8{flags[cpuPkg::SET_INPUT_B_TO_NOT_DB]}} & ~dbIn)
               | ({8{flags[cpuPkg::SET_INPUT_B_TO_ADL]}} & adlIn);

    // Binary only, the D flag never reaches here
    assign sum = {1'b0, aIn} + {1'b0, bIn} + {8'h00, carryIn};

    always_comb begin
        result   = 8'h00;
        carryOut = 1'b0;
        overflow = 1'b0;
        if (flags[cpuPkg::ALU_ADD]) begin
            result   = sum[7:0];
            carryOut = sum[8];
            // Same sign in, other sign out
            overflow = (aIn[7] == bIn[7]) && (sum[7] != aIn[7]);
        end else if (flags[cpuPkg::ALU_AND]) begin
            result = aIn & bIn;
        end else if (flags[cpuPkg::ALU_XOR]) begin
            result = aIn ^ bIn;
        end else if (flags[cpuPkg::ALU_OR]) begin
            result = aIn | bIn;
        end else if (flags[cpuPkg::ALU_R_SHIFT]) begin
            result   = {carryIn, aIn[7:1]};   // Rotate in the carry
            carryOut = aIn[0];
        end
    end

endmodule

`default_nettype wire

/* processStatusRegister.sv */
`default_nettype none

module processStatusRegister (
    input  wire                 clk,
    input  wire                 rstN,
    input  wire [7:0]           dbIn,
    input  wire cpuPkg::flags_t flags,
    input  wire                 aluCarry,
    input  wire                 aluOverflow,
    output cpuPkg::psr_t        psr,
    output logic [7:0]          psrToDb
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            psr <= cpuPkg::PSR_RESET;
        end else if (flags[cpuPkg::SET_PSR_ALL_TO_DB]) begin
            psr <= {dbIn[7:6], 1'b1, dbIn[4:0]};   // Bit 5 is hardwired
        end else begin
            if (flags[cpuPkg::SET_PSR_N_TO_DB7]) begin
                psr.n <= dbIn[7];
            end
            if (flags[cpuPkg::SET_PSR_Z_TO_DBZERO]) begin
                psr.z <= (dbIn == 8'h00);
            end
            if (flags[cpuPkg::SET_PSR_V_TO_ALU]) begin
                psr.v <= aluOverflow;
            end
            // Carry sources
            if (flags[cpuPkg::SET_PSR_C_TO_ALU]) begin
                psr.c <= aluCarry;
            end else if (flags[cpuPkg::SET_PSR_C_HIGH]) begin
                psr.c <= 1'b1;
            end else if (flags[cpuPkg::SET_PSR_C_LOW]) begin
                psr.c <= 1'b0;
            end
        end
    end

    assign psrToDb = psr;

    // Only one write of the carry priority chain per cycle
    aOneCarryWrite: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({flags[cpuPkg::SET_PSR_ALL_TO_DB], flags[cpuPkg::SET_PSR_C_TO_ALU],
                  flags[cpuPkg::SET_PSR_C_HIGH], flags[cpuPkg::SET_PSR_C_LOW]}))
        else $error("Conflicting PSR carry writes in one cycle");

endmodule

`default_nettype wire

/* microDecoder.sv */
`default_nettype none

module microDecoder (
    input  wire cpuPkg::microOp_t microOp,
    output cpuPkg::flags_t        flags
);
    logic [6:0]  dbHot;
    logic [6:0]  sbHot;
    logic [11:0] adlHot;
    logic [5:0]  adhHot;
    logic [3:0]  bridgeHot;
    logic [2:0]  aluBHot;
    logic [4:0]  opHot;
    logic [2:0]  carryHot;

    // Codes past the last defined value shift out and select nothing
    assign dbHot     = 7'b1 << microOp.dbSrc;
    assign sbHot     = 7'b1 << microOp.sbSrc;
    assign adlHot    = 12'b1 << microOp.adlSrc;
    assign adhHot    = 6'b1 << microOp.adhSrc;
    assign bridgeHot = 4'b1 << microOp.bridge;
    assign aluBHot   = 3'b1 << microOp.aluB;
    assign opHot     = 5'b1 << microOp.aluOp;
    assign carryHot  = 3'b1 << microOp.carrySel;

    always_comb begin
        flags = '0;
        // Bit 0 is the NONE code on these fields
        flags[cpuPkg::SET_DB_TO_ACC +: 6]  = dbHot[6:1];
        flags[cpuPkg::SET_SB_TO_X +: 6]    = sbHot[6:1];
        flags[cpuPkg::SET_ADL_TO_SP +: 11] = adlHot[11:1];
        flags[cpuPkg::SET_ADH_TO_PCH +: 5] = adhHot[5:1];
        flags[cpuPkg::SET_SB_TO_DB +: 3]   = bridgeHot[3:1];
        flags[cpuPkg::LOAD_X +: cpuPkg::NUMLOADS] = microOp.loads;
        flags[cpuPkg::PC_INC]  = microOp.pcOp[0];
        flags[cpuPkg::LOAD_PC] = microOp.pcOp[1];
        flags[cpuPkg::SET_INPUT_A_TO_SB]       = microOp.aluA;
        flags[cpuPkg::SET_INPUT_B_TO_DB +: 3]  = aluBHot;   // Code zero is DB here
        flags[cpuPkg::ALU_ADD +: 5]            = opHot;
        flags[cpuPkg::SET_ALU_CARRY_HIGH +: 2] = carryHot[2:1];
        case (microOp.psrOp)
            cpuPkg::PSR_NZ_DB: begin
                flags[cpuPkg::SET_PSR_N_TO_DB7]    = 1'b1;
                flags[cpuPkg::SET_PSR_Z_TO_DBZERO] = 1'b1;
            end
            cpuPkg::PSR_ALU: begin
                flags[cpuPkg::SET_PSR_C_TO_ALU] = 1'b1;
                flags[cpuPkg::SET_PSR_V_TO_ALU] = 1'b1;
            end
            cpuPkg::PSR_LOAD_DB: flags[cpuPkg::SET_PSR_ALL_TO_DB] = 1'b1;
            cpuPkg::PSR_SET_C:   flags[cpuPkg::SET_PSR_C_HIGH] = 1'b1;
            cpuPkg::PSR_CLR_C:   flags[cpuPkg::SET_PSR_C_LOW] = 1'b1;
            default: ;   // No status write
        endcase
    end

endmodule

`default_nettype wire

/* internalDataflow.sv */
`default_nettype none

module internalDataflow (
    input  wire                 clk,
    input  wire                 rstN,
    input  wire cpuPkg::flags_t flags,
    input  wire [7:0]           dataIn,
    output logic [7:0]          dataOut,      // DOR
    output logic [7:0]          addressLow,   // ABL
    output logic [7:0]          addressHigh,  // ABH
    output cpuPkg::psr_t        psr,
    output logic                aluCarryOut
);
    logic [7:0] xReg, yReg, accReg, spReg, aluHold, pchReg, pclReg;
    logic [7:0] dbDriven, sbDriven, adhDriven;   // Before the bridges
    logic [7:0] dataBus, stackBus, addressLowBus, addressHighBus;
    logic [7:0] aluResult, psrToDb;
    logic       aluOverflow, carryIn;
    logic [15:0] pcIncIn, pcNext;

    // Presets are constant drivers on the buses
    internalBus #(.INPUT_COUNT(6)) dataBusModule (
        .busSelect(flags[cpuPkg::SET_DB_TO_ACC +: 6]),
        .busInputs({8'hFF, dataIn, psrToDb, pchReg, pclReg, accReg}),
        .busOutput(dbDriven)
    );

    internalBus #(.INPUT_COUNT(6)) stackBusModule (
        .busSelect(flags[cpuPkg::SET_SB_TO_X +: 6]),
        .busInputs({8'hFF, accReg, aluHold, spReg, yReg, xReg}),
        .busOutput(sbDriven)
    );

    internalBus #(.INPUT_COUNT(11)) addressLowBusModule (
        .busSelect(flags[cpuPkg::SET_ADL_TO_SP +: 11]),
        .busInputs({8'h00, 8'hFF, 8'hFE, 8'hFD, 8'hFC, 8'hFB, 8'hFA,
                    dataIn, pclReg, aluHold, spReg}),
        .busOutput(addressLowBus)
    );

    internalBus #(.INPUT_COUNT(5)) addressHighBusModule (
        .busSelect(flags[cpuPkg::SET_ADH_TO_PCH +: 5]),
        .busInputs({8'hFF, 8'h01, 8'h00, dataIn, pchReg}),
        .busOutput(adhDriven)
    );

    // SB/DB and SB/ADH bridges, wired OR onto the receiving bus
    assign dataBus        = dbDriven | (flags[cpuPkg::SET_DB_TO_SB] ? sbDriven : 8'h00);
    assign stackBus       = sbDriven | (flags[cpuPkg::SET_SB_TO_DB] ? dbDriven : 8'h00);
    assign addressHighBus = adhDriven | (flags[cpuPkg::SET_ADH_TO_SB] ? sbDriven : 8'h00);

    // One incrementer for both PC paths
    assign pcIncIn = flags[cpuPkg::LOAD_PC] ? {addressHighBus, addressLowBus}
                                            : {pchReg, pclReg};
    assign pcNext  = pcIncIn + {15'h0000, flags[cpuPkg::PC_INC]};

    assign carryIn = flags[cpuPkg::SET_ALU_CARRY_HIGH]
                   | (flags[cpuPkg::SET_ALU_CARRY_TO_PSR_CARRY] & psr.c);

    alu alu (
        .dbIn(dataBus),
        .adlIn(addressLowBus),
        .sbIn(stackBus),
        .flags(flags),
        .carryIn(carryIn),
        .result(aluResult),
        .carryOut(aluCarryOut),
        .overflow(aluOverflow)
    );

    processStatusRegister psrReg (
        .clk(clk),
        .rstN(rstN),
        .dbIn(dataBus),
        .flags(flags),
        .aluCarry(aluCarryOut),
        .aluOverflow(aluOverflow),
        .psr(psr),
        .psrToDb(psrToDb)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            xReg        <= 8'h00;
            yReg        <= 8'h00;
            accReg      <= 8'h00;
            spReg       <= 8'h00;
            aluHold     <= 8'h00;
            addressLow  <= 8'h00;
            addressHigh <= 8'h00;
            dataOut     <= 8'h00;
            pchReg      <= cpuPkg::PCH_RESET;
            pclReg      <= cpuPkg::PCL_RESET;
        end else begin
            if (flags[cpuPkg::LOAD_X])   xReg <= stackBus;
            if (flags[cpuPkg::LOAD_Y])   yReg <= stackBus;
            if (flags[cpuPkg::LOAD_ACC]) accReg <= stackBus;
            if (flags[cpuPkg::LOAD_SP])  spReg <= stackBus;
            if (flags[cpuPkg::LOAD_ALU]) aluHold <= aluResult;
            if (flags[cpuPkg::LOAD_ABL]) addressLow <= addressLowBus;
            if (flags[cpuPkg::LOAD_ABH]) addressHigh <= addressHighBus;
            if (flags[cpuPkg::LOAD_DOR]) dataOut <= dataBus;
            {pchReg, pclReg} <= pcNext;   // Holds when neither PC flag is set
        end
    end

    // Decoder promises a single driver per bus
    aDbOneDriver:  assert property (@(posedge clk) disable iff (!rstN)
        $onehot0(flags[cpuPkg::SET_DB_TO_ACC +: 6]));
    aSbOneDriver:  assert property (@(posedge clk) disable iff (!rstN)
        $onehot0(flags[cpuPkg::SET_SB_TO_X +: 6]));
    aAdlOneDriver: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0(flags[cpuPkg::SET_ADL_TO_SP +: 11]));
    aAdhOneDriver: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0(flags[cpuPkg::SET_ADH_TO_PCH +: 5]));

    // Undefined aluOp codes decode to no operation at all
    aAluOpDefined: assert property (@(posedge clk) disable iff (!rstN)
        $onehot(flags[cpuPkg::ALU_ADD +: 5]));

    aPcLoadIncDriven: assert property (@(posedge clk) disable iff (!rstN)
        (flags[cpuPkg::LOAD_PC] && flags[cpuPkg::PC_INC]) |->
            (|flags[cpuPkg::SET_ADL_TO_SP +: 11])
            && ((|flags[cpuPkg::SET_ADH_TO_PCH +: 5]) || flags[cpuPkg::SET_ADH_TO_SB]));

endmodule

`default_nettype wire

/* cpuCore.sv */
`default_nettype none

module cpuCore (
    input  wire                   clk,
    input  wire                   rstN,
    input  wire cpuPkg::microOp_t microOp,
    input  wire [7:0]             dataIn,
    output logic [7:0]            dataOut,
    output logic [7:0]            addressLow,
    output logic [7:0]            addressHigh,
    output cpuPkg::psr_t          psr,
    output logic                  aluCarryOut
);
    cpuPkg::flags_t flags;   // Controls for the current cycle

    microDecoder decoder (
        .microOp(microOp),
        .flags(flags)
    );

    internalDataflow dataflow (
        .clk(clk),
        .rstN(rstN),
        .flags(flags),
        .dataIn(dataIn),
        .dataOut(dataOut),
        .addressLow(addressLow),
        .addressHigh(addressHigh),
        .psr(psr),
        .aluCarryOut(aluCarryOut)
    );

endmodule

`default_nettype wire

/* tb_cpuCore.sv */
`default_nettype none

module tb_cpuCore;
    localparam int NUM_PAIRS    = 40;
    localparam int RESET_CYCLES = 8;
    localparam int ALU_CYCLES   = NUM_PAIRS * (1 + 2 * 5);   // X load, then op and readback
    localparam int OTHER_CYCLES = 30;
    // A quarter above the expected run length
    localparam int TIMEOUT_CYCLES = (RESET_CYCLES + ALU_CYCLES + OTHER_CYCLES) * 5 / 4;

    logic             clk;
    logic             rstN;
    cpuPkg::microOp_t microOp;
    logic [7:0]       dataIn;
    logic [7:0]       dataOut;
    logic [7:0]       addressLow;
    logic [7:0]       addressHigh;
    cpuPkg::psr_t     psr;
    logic             aluCarryOut;

    logic [31:0]  rngState;
    cpuPkg::psr_t modelPsr;
    logic [15:0]  modelPc;
    logic         carrySeen;
    int           cycleCount = 0;

    cpuCore cpuCore_i (
        .clk(clk),
        .rstN(rstN),
        .microOp(microOp),
        .dataIn(dataIn),
        .dataOut(dataOut),
        .addressLow(addressLow),
        .addressHigh(addressHigh),
        .psr(psr),
        .aluCarryOut(aluCarryOut)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] t;
        t = s ^ (s << 13);
        t = t ^ (t >> 17);
        return t ^ (t << 5);
    endfunction

    function automatic cpuPkg::microOp_t routeOp(input logic [2:0] db, input logic [2:0] sb,
            input logic [3:0] adl, input logic [2:0] adh, input logic [1:0] br,
            input logic [7:0] loads, input logic [2:0] psrOp);
        cpuPkg::microOp_t op;
        op        = '0;   // Idle ALU is an add of zeros
        op.dbSrc  = db;
        op.sbSrc  = sb;
        op.adlSrc = adl;
        op.adhSrc = adh;
        op.bridge = br;
        op.loads  = loads;
        op.psrOp  = psrOp;
        return op;
    endfunction

    task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // Drive on the falling edge so results settle by the next one
    task automatic applyOp(input cpuPkg::microOp_t op, input logic [7:0] din);
        microOp = op;
        dataIn  = din;
        #1 carrySeen = aluCarryOut;
        @(negedge clk);
        microOp = '0;
    endtask

    // Binary reference ALU
    task automatic aluModel(input logic [2:0] op, input logic [7:0] a, input logic [7:0] b,
            input logic cin, output logic [7:0] r, output logic cout, output logic ovf);
        int         total;
        logic [7:0] signFlip;
        total = int'(a) + int'(b) + int'(cin);
        r     = 8'h00;
        cout  = 1'b0;
        ovf   = 1'b0;
        case (op)
            cpuPkg::OP_ADD: begin
                r        = total[7:0];
                cout     = total > 255;
                signFlip = (a ^ r) & (b ^ r);   // Both operands disagree with the result sign
                ovf      = signFlip[7];
            end
            cpuPkg::OP_AND: r = a & b;
            cpuPkg::OP_XOR: r = a ^ b;
            cpuPkg::OP_OR:  r = a | b;
            default: begin
                r    = (a >> 1) | {cin, 7'h00};
                cout = a[0];
            end
        endcase
    endtask

    task automatic pcReadback();
        applyOp(routeOp(cpuPkg::DB_NONE, cpuPkg::SB_NONE, cpuPkg::ADL_PCL, cpuPkg::ADH_PCH,
            cpuPkg::BR_NONE, cpuPkg::LD_ABL | cpuPkg::LD_ABH, cpuPkg::PSR_NONE), 8'h00);
        checkByte("addressLow", addressLow, modelPc[7:0]);
        checkByte("addressHigh", addressHigh, modelPc[15:8]);
    endtask

    task automatic verifyReset();
        checkByte("addressLow", addressLow, 8'h00);
        checkByte("addressHigh", addressHigh, 8'h00);
        checkByte("dataOut", dataOut, 8'h00);
        checkByte("psr", psr, modelPsr);
        pcReadback();   // Reset PC
    endtask

    task automatic moveDataBytes();
        logic [7:0] v;
        rngState = xorshift(rngState);
        v = rngState[7:0];
        applyOp(routeOp(cpuPkg::DB_DATA, cpuPkg::SB_NONE, cpuPkg::ADL_NONE, cpuPkg::ADH_NONE,
            cpuPkg::BR_NONE, cpuPkg::LD_DOR, cpuPkg::PSR_NONE), v);
        checkByte("dataOut", dataOut, v);
        v = rngState[15:8];
        applyOp(routeOp(cpuPkg::DB_DATA, cpuPkg::SB_NONE, cpuPkg::ADL_NONE, cpuPkg::ADH_NONE,
            cpuPkg::BR_SB_FROM_DB, cpuPkg::LD_ACC, cpuPkg::PSR_NONE), v);
        applyOp(routeOp(cpuPkg::DB_ACC, cpuPkg::SB_NONE, cpuPkg::ADL_NONE, cpuPkg::ADH_NONE,
            cpuPkg::BR_NONE, cpuPkg::LD_DOR, cpuPkg::PSR_NONE), 8'h00);
        checkByte("dataOut", dataOut, v);
        v = rngState[23:16];
        // dataIn to X, X to Y, Y to ACC, ACC out
        applyOp(routeOp(cpuPkg::DB_DATA, cpuPkg::SB_NONE, cpuPkg::ADL_NONE, cpuPkg::ADH_NONE,
            cpuPkg::BR_SB_FROM_DB, cpuPkg::LD_X, cpuPkg::PSR_NONE), v);
        applyOp(routeOp(cpuPkg::DB_NONE, cpuPkg::SB_X, cpuPkg::ADL_NONE, cpuPkg::ADH_NONE,
            cpuPkg::BR_NONE, cpuPkg::LD_Y, cpuPkg::PSR_NONE), 8'h00);
        applyOp(routeOp(cpuPkg::DB_NONE, cpuPkg::SB_Y, cpuPkg::ADL_NONE, cpuPkg::ADH_NONE,
            cpuPkg::BR_NONE, cpuPkg::LD_ACC, cpuPkg::PSR_NONE), 8'h00);
        applyOp(routeOp(cpuPkg::DB_ACC, cpuPkg::SB_NONE, cpuPkg::ADL_NONE, cpuPkg::ADH_NONE,
            cpuPkg::BR_NONE, cpuPkg::LD_DOR, cpuPkg::PSR_NONE), 8'h00);
        checkByte("dataOut", dataOut, v);
    endtask

    task automatic runAluPairs();
        logic [2:0] aluOps [5] = '{cpuPkg::OP_ADD, cpuPkg::OP_AND, cpuPkg::OP_XOR,
                                   cpuPkg::OP_OR, cpuPkg::OP_SHR};
        cpuPkg::microOp_t op;
        logic [7:0] a, b, r;
        logic       cin, cout, ovf;
        logic [1:0] csel;
        for (int i = 0; i < NUM_PAIRS; i++) begin
            rngState = xorshift(rngState);
            a = rngState[7:0];
            b = rngState[15:8];
            applyOp(routeOp(cpuPkg::DB_DATA, cpuPkg::SB_NONE, cpuPkg::ADL_NONE,
                cpuPkg::ADH_NONE, cpuPkg::BR_SB_FROM_DB, cpuPkg::LD_X, cpuPkg::PSR_NONE), a);
            for (int k = 0; k < 5; k++) begin
                csel = 2'((i + k) % 3);   // Rotate through zero, one and PSR carry
                cin  = (csel == cpuPkg::CARRY_ONE) || (csel == cpuPkg::CARRY_PSR && modelPsr.c);
                op   = routeOp(cpuPkg::DB_DATA, cpuPkg::SB_X, cpuPkg::ADL_NONE,
                    cpuPkg::ADH_NONE, cpuPkg::BR_NONE, cpuPkg::LD_ALU, cpuPkg::PSR_ALU);
                op.aluA     = cpuPkg::ALUA_SB;
                op.aluB     = cpuPkg::ALUB_DB;
                op.aluOp    = aluOps[k];
                op.carrySel = csel;
                aluModel(aluOps[k], a, b, cin, r, cout, ovf);
                applyOp(op, b);
                checkByte("aluCarryOut", {7'h00, carrySeen}, {7'h00, cout});
                modelPsr.c = cout;
                modelPsr.v = ovf;
                // Hold register out on ADL, and onto DB through the bridge for N and Z
                applyOp(routeOp(cpuPkg::DB_NONE, cpuPkg::SB_ALU, cpuPkg::ADL_ALU,
                    cpuPkg::ADH_NONE, cpuPkg::BR_DB_FROM_SB, cpuPkg::LD_ABL,
                    cpuPkg::PSR_NZ_DB), 8'h00);
                modelPsr.n = r[7];
                modelPsr.z = (r == 8'h00);
                checkByte("addressLow", addressLow, r);
                checkByte("psr", psr, modelPsr);
            end
        end
    endtask

    task automatic stepProgramCounter();
        cpuPkg::microOp_t op;
        logic [7:0] v;
        op = routeOp(cpuPkg::DB_NONE, cpuPkg::SB_NONE, cpuPkg::ADL_FF, cpuPkg::ADH_01,
            cpuPkg::BR_NONE, 8'h00, cpuPkg::PSR_NONE);
        op.pcOp = cpuPkg::PCOP_LOAD;
        applyOp(op, 8'h00);
        modelPc = 16'h01FF;
        pcReadback();
        op      = '0;
        op.pcOp = cpuPkg::PCOP_INC;
        applyOp(op, 8'h00);
        modelPc = modelPc + 16'd1;   // Carry out of PCL
        pcReadback();
        rngState = xorshift(rngState);
        v  = rngState[7:0];
        op = routeOp(cpuPkg::DB_NONE, cpuPkg::SB_NONE, cpuPkg::ADL_DATA, cpuPkg::ADH_DATA,
            cpuPkg::BR_NONE, 8'h00, cpuPkg::PSR_NONE);
        op.pcOp = cpuPkg::PCOP_LOAD_INC;
        applyOp(op, v);
        modelPc = {v, v} + 16'd1;
        pcReadback();
        op = routeOp(cpuPkg::DB_NONE, cpuPkg::SB_NONE, cpuPkg::ADL_00, cpuPkg::ADH_FF,
            cpuPkg::BR_NONE, 8'h00, cpuPkg::PSR_NONE);
        op.pcOp = cpuPkg::PCOP_LOAD;
        applyOp(op, 8'h00);
        modelPc = 16'hFF00;
        pcReadback();
    endtask

    task automatic loadPresets();
        logic [3:0] adlCodes [7] = '{cpuPkg::ADL_FA, cpuPkg::ADL_FB, cpuPkg::ADL_FC,
            cpuPkg::ADL_FD, cpuPkg::ADL_FE, cpuPkg::ADL_FF, cpuPkg::ADL_00};
        logic [7:0] adlValues [7] = '{8'hFA, 8'hFB, 8'hFC, 8'hFD, 8'hFE, 8'hFF, 8'h00};
        logic [2:0] adhCodes [3] = '{cpuPkg::ADH_00, cpuPkg::ADH_01, cpuPkg::ADH_FF};
        logic [7:0] adhValues [3] = '{8'h00, 8'h01, 8'hFF};
        logic [7:0] v;
        for (int k = 0; k < 7; k++) begin
            applyOp(routeOp(cpuPkg::DB_NONE, cpuPkg::SB_NONE, adlCodes[k], cpuPkg::ADH_NONE,
                cpuPkg::BR_NONE, cpuPkg::LD_ABL, cpuPkg::PSR_NONE), 8'h00);
            checkByte("addressLow", addressLow, adlValues[k]);
        end
        for (int k = 0; k < 3; k++) begin
            applyOp(routeOp(cpuPkg::DB_NONE, cpuPkg::SB_NONE, cpuPkg::ADL_NONE, adhCodes[k],
                cpuPkg::BR_NONE, cpuPkg::LD_ABH, cpuPkg::PSR_NONE), 8'h00);
            checkByte("addressHigh", addressHigh, adhValues[k]);
        end
        rngState = xorshift(rngState);
        v = rngState[7:0] & 8'hDE;   // Bit 5 must still read one, C starts clear
        applyOp(routeOp(cpuPkg::DB_DATA, cpuPkg::SB_NONE, cpuPkg::ADL_NONE, cpuPkg::ADH_NONE,
            cpuPkg::BR_NONE, 8'h00, cpuPkg::PSR_LOAD_DB), v);
        modelPsr = v | 8'h20;
        checkByte("psr", psr, modelPsr);
        applyOp(routeOp(cpuPkg::DB_NONE, cpuPkg::SB_NONE, cpuPkg::ADL_NONE, cpuPkg::ADH_NONE,
            cpuPkg::BR_NONE, 8'h00, cpuPkg::PSR_SET_C), 8'h00);
        modelPsr.c = 1'b1;
        checkByte("psr", psr, modelPsr);
        applyOp(routeOp(cpuPkg::DB_NONE, cpuPkg::SB_NONE, cpuPkg::ADL_NONE, cpuPkg::ADH_NONE,
            cpuPkg::BR_NONE, 8'h00, cpuPkg::PSR_CLR_C), 8'h00);
        modelPsr.c = 1'b0;
        checkByte("psr", psr, modelPsr);
    endtask

    initial begin
        rstN     = 1'b0;
        microOp  = '0;
        dataIn   = 8'h00;
        rngState = 32'd39;
        modelPsr = 8'h20;
        modelPc  = 16'hAABB;
        repeat (RESET_CYCLES) @(negedge clk);
        rstN = 1'b1;
        verifyReset();
        moveDataBytes();
        runAluPairs();
        stepProgramCounter();
        loadPresets();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
cpuPkg.sv
internalBus.sv
alu.sv
processStatusRegister.sv
microDecoder.sv
internalDataflow.sv
cpuCore.sv
tb_cpuCore.sv

/* run.sh */
#!/bin/sh
# Build the cpuCore testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_cpuCore -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
